// ==== yscaler.f ====
rtl/yscale_pkg.sv
rtl/line_buf_if.sv
rtl/blend_if.sv
rtl/line_buffer.sv
rtl/line_writer.sv
rtl/scale_stepper.sv
rtl/yscale_ctrl.sv
rtl/line_reader.sv
rtl/pixel_blend.sv
rtl/yscaler.sv
sim/tb_yscaler.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing -Wall
TOP       := tb_yscaler
FILELIST  := yscaler.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_yscaler.sv ====
module tb_yscaler import yscale_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_W = 8;
	localparam int MAX_H = 8;
	localparam logic [31:0] SEED = 32'he700_8daa;

	// Input plus output pixels of each frame
	localparam int EQ_PIX = 5 * (6 + 6);
	localparam int UP_PIX = 6 * (4 + 8);
	localparam int DOWN_PIX = 7 * (8 + 3);
	localparam int RESTART_PIX = 5 * (4 + 4);
	localparam int CYCLE_LIMIT =
		4 * (EQ_PIX + UP_PIX + DOWN_PIX + UP_PIX + UP_PIX + RESTART_PIX) + 2000;

	logic   clk;
	logic   i_resetn;
	logic   i_fsync;
	reso_t  i_s_width;
	reso_t  i_s_height;
	reso_t  i_m_height;
	logic   i_s_tvalid;
	pixel_t i_s_tdata;
	logic   i_s_tlast;
	logic   o_s_tready;
	logic   o_m_tvalid;
	pixel_t o_m_tdata;
	logic   o_m_tlast;
	logic   o_m_tuser;
	logic   i_m_tready;

	pixel_t src [MAX_H][MAX_W];
	pixel_t exp_px [$];
	pixel_t got_px [$];
	pixel_t ref_px [$];
	int     accepted;
	bit     stop_input;
	int     cycles;

	yscaler i_yscaler (
		.clk        (clk),
		.i_resetn   (i_resetn),
		.i_fsync    (i_fsync),
		.i_s_width  (i_s_width),
		.i_s_height (i_s_height),
		.i_m_height (i_m_height),
		.i_s_tvalid (i_s_tvalid),
		.i_s_tdata  (i_s_tdata),
		.i_s_tlast  (i_s_tlast),
		.o_s_tready (o_s_tready),
		.o_m_tvalid (o_m_tvalid),
		.o_m_tdata  (o_m_tdata),
		.o_m_tlast  (o_m_tlast),
		.o_m_tuser  (o_m_tuser),
		.i_m_tready (i_m_tready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		fail_run("Timeout: the run went past its cycle limit");
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input string what,
			input int want, input int got);
		fail_run($sformatf("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
			name, what, want, got));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic void fill_random(input int w, input int h);
		for (int y = 0; y < h; y++)
			for (int x = 0; x < w; x++)
				src[y][x] = pixel_t'($urandom);
	endfunction

	// Walks the two phases line by line and picks a quarter weight
	function automatic void build_expected(input int w, input int sh, input int mh);
		int  k;
		int  kp;
		bit  lastp;
		bit  first;
		int  in_ph;
		int  out_ph;
		int  diff;
		int  wt;
		int  thr [SPLIT_NUM];
		exp_px.delete();
		k = 0;
		kp = 0;
		lastp = (sh == 1);
		first = 1'b1;
		for (int i = 0; i < SPLIT_NUM; i++)
			thr[i] = mh * (i + 1) / SPLIT_NUM;
		for (int j = 0; j < mh; j++) begin
			out_ph = sh * (2 * j + 1);
			in_ph = mh * (2 * k + 1);
			while (!(in_ph >= out_ph || lastp)) begin
				kp = k;
				if (k == sh - 1) begin
					lastp = 1'b1;
				end else begin
					k++;
					first = 1'b0;
				end
				in_ph = mh * (2 * k + 1);
			end
			diff = in_ph - out_ph;
			wt = SPLIT_NUM;
			for (int i = 0; i < SPLIT_NUM; i++)
				if (wt == SPLIT_NUM && diff <= thr[i])
					wt = i;
			if (first || lastp)
				wt = SPLIT_NUM;
			for (int x = 0; x < w; x++)
				exp_px.push_back(pixel_t'((src[kp][x] * wt
					+ src[k][x] * (SPLIT_NUM - wt)) / SPLIT_NUM));
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stream drivers

	task automatic reset_dut(input int w, input int sh, input int mh);
		@(posedge clk);
		i_resetn <= 1'b0;
		i_s_width <= reso_t'(w);
		i_s_height <= reso_t'(sh);
		i_m_height <= reso_t'(mh);
		repeat (8) @(posedge clk);
		i_resetn <= 1'b1;
	endtask

	task automatic send_frame(input int w, input int h);
		int x;
		int y;
		x = 0;
		y = 0;
		accepted = 0;
		@(posedge clk);
		while (y < h && !stop_input) begin
			i_s_tvalid <= 1'b1;
			i_s_tdata <= src[y][x];
			i_s_tlast <= (x == w - 1);
			@(negedge clk);
			if (o_s_tready) begin
				accepted++;
				if (x == w - 1) begin
					x = 0;
					y++;
				end else begin
					x++;
				end
			end
			@(posedge clk);
		end
		i_s_tvalid <= 1'b0;
		i_s_tlast <= 1'b0;
	endtask

	// Checks n output pixels, optionally with random back-pressure
	task automatic collect(input string name, input int w, input int n, input bit stall);
		int     got;
		int     col;
		bit     holding;
		pixel_t held;
		pixel_t want;
		got = 0;
		col = 0;
		holding = 1'b0;
		got_px.delete();
		while (got < n) begin
			@(posedge clk);
			i_m_tready <= stall ? (($urandom % 3) != 0) : 1'b1;
			@(negedge clk);
			if (holding) begin
				assert (o_m_tvalid)
				else fail_run($sformatf("%s: output valid dropped during a stall", name));
				assert (o_m_tdata == held)
				else report_value(name, "held data", held, o_m_tdata);
			end
			holding = 1'b0;
			if (o_m_tvalid && i_m_tready) begin
				want = exp_px.pop_front();
				assert (o_m_tdata == want)
				else report_value(name, $sformatf("pixel %0d", got), want, o_m_tdata);
				assert (o_m_tlast == (col == w - 1))
				else report_value(name, $sformatf("tlast %0d", got), col == w - 1, o_m_tlast);
				assert (o_m_tuser == (got == 0))
				else report_value(name, $sformatf("tuser %0d", got), got == 0, o_m_tuser);
				got_px.push_back(o_m_tdata);
				col = (col == w - 1) ? 0 : col + 1;
				got++;
			end else if (o_m_tvalid) begin
				holding = 1'b1;
				held = o_m_tdata;
			end
		end
	endtask

	// No extra pixels after the frame's last line
	task automatic expect_quiet(input string name, input int n);
		@(posedge clk);
		i_m_tready <= 1'b1;
		repeat (n) begin
			@(negedge clk);
			assert (!o_m_tvalid)
			else fail_run($sformatf("%s: output pixel after end of frame", name));
		end
	endtask

	task automatic run_frame(input string name, input int w, input int sh,
			input int mh, input bit stall);
		build_expected(w, sh, mh);
		reset_dut(w, sh, mh);
		stop_input = 1'b0;
		fork
			send_frame(w, sh);
			collect(name, w, w * mh, stall);
		join
		assert (accepted == w * sh)
		else report_value(name, "accepted pixels", w * sh, accepted);
		expect_quiet(name, 16);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		reset_dut(5, 6, 6);
		@(negedge clk);
		assert (o_s_tready == 1'b0)
		else report_value("reset_state", "o_s_tready", 0, o_s_tready);
		assert (o_m_tvalid == 1'b0)
		else report_value("reset_state", "o_m_tvalid", 0, o_m_tvalid);
		assert (o_m_tuser == 1'b1)
		else report_value("reset_state", "o_m_tuser", 1, o_m_tuser);
	endtask

	task automatic test_equal_heights();
		fill_random(5, 6);
		run_frame("equal_heights", 5, 6, 6, 1'b0);
		// Weight 0 means each output line is its input line
		for (int i = 0; i < 30; i++)
			assert (got_px[i] == src[i / 5][i % 5])
			else report_value("equal_heights", $sformatf("copy %0d", i),
				src[i / 5][i % 5], got_px[i]);
	endtask

	task automatic test_upscale();
		fill_random(6, 4);
		run_frame("upscale", 6, 4, 8, 1'b0);
		ref_px = got_px;
	endtask

	task automatic test_downscale();
		fill_random(7, 8);
		run_frame("downscale", 7, 8, 3, 1'b0);
	endtask

	task automatic test_upscale_stalls();
		run_frame("upscale_stalls", 6, 4, 8, 1'b1);
		assert (got_px.size() == ref_px.size())
		else report_value("upscale_stalls", "pixel count", ref_px.size(), got_px.size());
		for (int i = 0; i < ref_px.size(); i++)
			assert (got_px[i] == ref_px[i])
			else report_value("upscale_stalls", $sformatf("rerun %0d", i),
				ref_px[i], got_px[i]);
	endtask

	task automatic test_fsync_restart();
		fill_random(6, 4);
		build_expected(6, 4, 8);
		reset_dut(6, 4, 8);
		stop_input = 1'b0;
		fork
			send_frame(6, 4);
			begin
				collect("fsync_abort", 6, 10, 1'b0);
				stop_input = 1'b1;
			end
		join
		// New sizes are latched during the sync pulse
		fill_random(5, 4);
		build_expected(5, 4, 4);
		stop_input = 1'b0;
		@(posedge clk);
		i_fsync <= 1'b1;
		i_s_width <= reso_t'(5);
		i_s_height <= reso_t'(4);
		i_m_height <= reso_t'(4);
		@(posedge clk);
		i_fsync <= 1'b0;
		fork
			send_frame(5, 4);
			collect("fsync_restart", 5, 20, 1'b0);
		join
		assert (accepted == 20)
		else report_value("fsync_restart", "accepted pixels", 20, accepted);
		expect_quiet("fsync_restart", 16);
	endtask

	initial begin
		i_resetn = 1'b0;
		i_fsync = 1'b0;
		i_s_width = '0;
		i_s_height = '0;
		i_m_height = '0;
		i_s_tvalid = 1'b0;
		i_s_tdata = '0;
		i_s_tlast = 1'b0;
		i_m_tready = 1'b0;
		stop_input = 1'b0;
		accepted = 0;
		void'($urandom(SEED));

		test_reset_state();
		test_equal_heights();
		test_upscale();
		test_upscale_stalls();
		test_downscale();
		test_fsync_restart();

		$display("sim passed");
		$finish;
	end

endmodule

// ==== rtl/yscaler.sv ====
module yscaler import yscale_pkg::*; (
	input  logic   clk,
	input  logic   i_resetn,
	input  logic   i_fsync,
	input  reso_t  i_s_width,
	input  reso_t  i_s_height,
	input  reso_t  i_m_height,
	input  logic   i_s_tvalid,
	input  pixel_t i_s_tdata,
	input  logic   i_s_tlast,
	output logic   o_s_tready,
	output logic   o_m_tvalid,
	output pixel_t o_m_tdata,
	output logic   o_m_tlast,
	output logic   o_m_tuser,
	input  logic   i_m_tready
);

	logic               int_reset;
	logic [BUF_NUM-1:0] wr_en;
	reso_t              wr_addr;
	pixel_t             wr_data;
	logic               rd_en;
	reso_t              rd_addr;
	pixel_t             rd_data [BUF_NUM];
	logic               step_in;
	logic               step_out;
	logic               line_done;
	logic               need_line;
	logic               last_in_line;
	logic               last_out_line;
	logic               line_go;
	logic               line_end;
	ratio_t             weight;

	line_buf_if lb ();
	blend_if    bl ();

	// Frame sync restarts everything, like a reset
	assign int_reset = !i_resetn || i_fsync;

	////////////////////////////////////////////////////////////////////////////
	// Input side

	line_writer u_writer (
		.clk        (clk),
		.int_reset  (int_reset),
		.i_s_height (i_s_height),
		.i_s_tvalid (i_s_tvalid),
		.i_s_tdata  (i_s_tdata),
		.i_s_tlast  (i_s_tlast),
		.o_s_tready (o_s_tready),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data),
		.lb         (lb)
	);

	for (genvar i = 0; i < BUF_NUM; i++) begin : g_buf
		line_buffer u_buf (
			.clk       (clk),
			.i_wr_en   (wr_en[i]),
			.i_wr_addr (wr_addr),
			.i_wr_data (wr_data),
			.i_rd_en   (rd_en),
			.i_rd_addr (rd_addr),
			.o_rd_data (rd_data[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Line control

	scale_stepper u_stepper (
		.clk             (clk),
		.int_reset       (int_reset),
		.i_s_height      (i_s_height),
		.i_m_height      (i_m_height),
		.i_step_in       (step_in),
		.i_step_out      (step_out),
		.i_line_done     (line_done),
		.o_need_line     (need_line),
		.o_last_in_line  (last_in_line),
		.o_last_out_line (last_out_line),
		.o_weight        (weight)
	);

	yscale_ctrl u_ctrl (
		.clk             (clk),
		.int_reset       (int_reset),
		.i_need_line     (need_line),
		.i_last_in_line  (last_in_line),
		.i_last_out_line (last_out_line),
		.i_line_end      (line_end),
		.o_step_in       (step_in),
		.o_step_out      (step_out),
		.o_line_done     (line_done),
		.o_line_go       (line_go),
		.lb              (lb)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side

	line_reader u_reader (
		.clk        (clk),
		.int_reset  (int_reset),
		.i_s_width  (i_s_width),
		.i_line_go  (line_go),
		.i_weight   (weight),
		.i_rd_data  (rd_data),
		.o_rd_en    (rd_en),
		.o_rd_addr  (rd_addr),
		.o_line_end (line_end),
		.lb         (lb),
		.bl         (bl)
	);

	pixel_blend u_blend (
		.clk        (clk),
		.int_reset  (int_reset),
		.bl         (bl),
		.o_m_tvalid (o_m_tvalid),
		.o_m_tdata  (o_m_tdata),
		.o_m_tlast  (o_m_tlast),
		.o_m_tuser  (o_m_tuser),
		.i_m_tready (i_m_tready)
	);

endmodule

// ==== rtl/pixel_blend.sv ====
module pixel_blend import yscale_pkg::*; (
	input  logic   clk,
	input  logic   int_reset,
	blend_if.dst   bl,
	output logic   o_m_tvalid,
	output pixel_t o_m_tdata,
	output logic   o_m_tlast,
	output logic   o_m_tuser,
	input  logic   i_m_tready
);

	ratio_t                             weight_cur;
	logic [PIXEL_WIDTH+RATIO_WIDTH-1:0] sum;
	logic                               take;

	assign bl.ready = !o_m_tvalid || i_m_tready;
	assign take = bl.valid && bl.ready;

	assign weight_cur = ratio_t'(SPLIT_NUM) - bl.weight_prev;
	assign sum = bl.pix_prev * bl.weight_prev + bl.pix_cur * weight_cur;

	always_ff @(posedge clk) begin
		if (take)
			o_m_tdata <= pixel_t'(sum / SPLIT_NUM);
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_m_tvalid <= 1'b0;
			o_m_tlast <= 1'b0;
			o_m_tuser <= 1'b1;
		end else begin
			if (take) begin
				o_m_tvalid <= 1'b1;
				o_m_tlast <= bl.last;
			end else if (i_m_tready) begin
				o_m_tvalid <= 1'b0;
			end
			// Start of frame rides on the first pixel only
			if (o_m_tvalid && i_m_tready)
				o_m_tuser <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (int_reset)
		o_m_tvalid && !i_m_tready |=> $stable(o_m_tdata));

endmodule

// ==== rtl/line_reader.sv ====
module line_reader import yscale_pkg::*; (
	input  logic       clk,
	input  logic       int_reset,
	input  reso_t      i_s_width,
	input  logic       i_line_go,
	input  ratio_t     i_weight,
	input  pixel_t     i_rd_data [BUF_NUM],
	output logic       o_rd_en,
	output reso_t      o_rd_addr,
	output logic       o_line_end,
	line_buf_if.reader lb,
	blend_if.src       bl
);

	reso_t s_width;
	reso_t col;
	logic  active;
	logic  pend;
	logic  pend_last;
	logic  room;
	logic  hand;

	// pend marks buffer outputs holding a pixel not yet staged
	assign room = !bl.valid || bl.ready;
	assign hand = pend && room;
	assign o_rd_en = active && (!pend || room) && !pend_last;
	assign o_rd_addr = col;

	always_ff @(posedge clk) begin
		if (int_reset)
			s_width <= i_s_width;
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			active <= 1'b0;
			col <= '0;
			pend <= 1'b0;
			pend_last <= 1'b0;
			o_line_end <= 1'b0;
			bl.valid <= 1'b0;
			bl.last <= 1'b0;
		end else begin
			o_line_end <= hand && pend_last;
			if (i_line_go)
				active <= 1'b1;
			else if (hand && pend_last)
				active <= 1'b0;
			if (!active) begin
				col <= '0;
				pend_last <= 1'b0;
			end else if (o_rd_en) begin
				col <= col + reso_t'(1);
				pend_last <= (col == reso_t'(s_width - 1'b1));
			end
			if (o_rd_en)
				pend <= 1'b1;
			else if (room)
				pend <= 1'b0;
			if (hand) begin
				bl.valid <= 1'b1;
				bl.last <= pend_last;
			end else if (bl.ready) begin
				bl.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hand) begin
			bl.pix_prev <= i_rd_data[lb.rd_sel_prev];
			bl.pix_cur <= i_rd_data[lb.rd_sel];
			bl.weight_prev <= i_weight;
		end
	end

endmodule

// ==== rtl/yscale_ctrl.sv ====
module yscale_ctrl import yscale_pkg::*; (
	input  logic     clk,
	input  logic     int_reset,
	input  logic     i_need_line,
	input  logic     i_last_in_line,
	input  logic     i_last_out_line,
	input  logic     i_line_end,
	output logic     o_step_in,
	output logic     o_step_out,
	output logic     o_line_done,
	output logic     o_line_go,
	line_buf_if.ctrl lb
);

	typedef enum logic [2:0] {
		IDLE,
		ADVANCE,
		WEIGH,
		EMIT,
		DONE,
		FINISHED
	} state_t;

	state_t state;
	logic   step_in_q;
	logic   line_go_q;
	logic   cur_valid;

	assign cur_valid = lb.buf_valid[lb.rd_sel];

	assign o_step_in = step_in_q;
	assign lb.buf_release = step_in_q;
	assign o_step_out = (state == ADVANCE);
	assign o_line_done = (state == DONE);
	assign o_line_go = line_go_q;

	////////////////////////////////////////////////////////////////////////////
	// Line sequencing

	always_ff @(posedge clk) begin
		if (int_reset) begin
			state <= IDLE;
			step_in_q <= 1'b0;
			line_go_q <= 1'b0;
		end else begin
			step_in_q <= 1'b0;
			line_go_q <= 1'b0;
			case (state)
				IDLE: begin
					// Stepper counters settle during the step_in cycle
					if (!step_in_q && cur_valid) begin
						if (i_need_line)
							state <= ADVANCE;
						else
							step_in_q <= 1'b1;
					end
				end
				ADVANCE: state <= WEIGH;
				WEIGH: begin
					state <= EMIT;
					line_go_q <= 1'b1;
				end
				EMIT: begin
					if (i_line_end)
						state <= DONE;
				end
				DONE: state <= i_last_out_line ? FINISHED : IDLE;
				default: state <= FINISHED;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read selection

	always_ff @(posedge clk) begin
		if (int_reset) begin
			lb.rd_sel <= '0;
			lb.rd_sel_prev <= '0;
			lb.first_line <= 1'b1;
		end else if (step_in_q) begin
			lb.rd_sel_prev <= lb.rd_sel;
			if (!i_last_in_line) begin
				lb.rd_sel <= lb.rd_sel + buf_sel_t'(1);
				lb.first_line <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (int_reset)
		!(o_step_in && o_step_out));

	// Writer's last-line tag agrees with the stepper's line count
	assert property (@(posedge clk) disable iff (int_reset)
		cur_valid |-> lb.buf_last_line[lb.rd_sel] == i_last_in_line);

endmodule

// ==== rtl/scale_stepper.sv ====
module scale_stepper import yscale_pkg::*; (
	input  logic   clk,
	input  logic   int_reset,
	input  reso_t  i_s_height,
	input  reso_t  i_m_height,
	input  logic   i_step_in,
	input  logic   i_step_out,
	input  logic   i_line_done,
	output logic   o_need_line,
	output logic   o_last_in_line,
	output logic   o_last_out_line,
	output ratio_t o_weight
);

	reso_t  s_height;
	reso_t  m_height;
	reso_t  thr [SPLIT_NUM];
	reso_t  in_left;
	reso_t  out_left;
	phase_t in_phase;
	phase_t out_phase;
	phase_t diff;
	logic   first_line;
	logic   last_prev;
	logic   single;
	logic   weigh;
	ratio_t weight_next;

	// Both taps sit on the last line once last_prev is set
	assign o_need_line = (in_phase >= out_phase) || last_prev;
	assign o_last_out_line = (out_left == reso_t'(1));

	always_ff @(posedge clk) begin
		if (int_reset) begin
			s_height <= i_s_height;
			m_height <= i_m_height;
			for (int i = 0; i < SPLIT_NUM; i++) begin
				thr[i] <= reso_t'(phase_t'(i_m_height) * (i + 1) / SPLIT_NUM);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			in_phase <= phase_t'(i_m_height);
			in_left <= i_s_height;
			o_last_in_line <= (i_s_height == reso_t'(1));
			last_prev <= (i_s_height == reso_t'(1));
			first_line <= 1'b1;
		end else if (i_step_in) begin
			last_prev <= o_last_in_line;
			if (!o_last_in_line) begin
				in_phase <= in_phase + phase_t'({m_height, 1'b0});
				in_left <= in_left - reso_t'(1);
				o_last_in_line <= (in_left == reso_t'(2));
				first_line <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			out_phase <= phase_t'(i_s_height);
			out_left <= i_m_height;
		end else if (i_line_done) begin
			out_phase <= out_phase + phase_t'({s_height, 1'b0});
			out_left <= out_left - reso_t'(1);
		end
	end

	// Difference first, thresholds compared a cycle later
	always_ff @(posedge clk) begin
		if (i_step_out) begin
			diff <= in_phase - out_phase;
			single <= first_line || last_prev;
		end
	end

	always_comb begin
		weight_next = ratio_t'(SPLIT_NUM);
		for (int i = SPLIT_NUM - 1; i >= 0; i--) begin
			if (diff <= phase_t'(thr[i]))
				weight_next = ratio_t'(i);
		end
		if (single)
			weight_next = ratio_t'(SPLIT_NUM);
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			weigh <= 1'b0;
			o_weight <= '0;
		end else begin
			weigh <= i_step_out;
			if (weigh)
				o_weight <= weight_next;
		end
	end

endmodule

// ==== rtl/line_writer.sv ====
module line_writer import yscale_pkg::*; (
	input  logic               clk,
	input  logic               int_reset,
	input  reso_t              i_s_height,
	input  logic               i_s_tvalid,
	input  pixel_t             i_s_tdata,
	input  logic               i_s_tlast,
	output logic               o_s_tready,
	output logic [BUF_NUM-1:0] o_wr_en,
	output reso_t              o_wr_addr,
	output pixel_t             o_wr_data,
	line_buf_if.writer         lb
);

	logic [BUF_NUM-1:0] wr_act;
	reso_t              col;
	reso_t              lines_left;
	logic               last_line;
	logic               s_next;
	logic               s_last;

	assign s_next = i_s_tvalid && o_s_tready;
	assign s_last = s_next && i_s_tlast;

	always_ff @(posedge clk) begin
		if (int_reset) begin
			wr_act <= BUF_NUM'(1);
			o_s_tready <= 1'b0;
			o_wr_en <= '0;
			col <= '0;
			lines_left <= i_s_height;
			last_line <= (i_s_height == reso_t'(1));
		end else begin
			o_wr_en <= s_next ? wr_act : '0;
			if (s_next)
				col <= i_s_tlast ? '0 : col + reso_t'(1);
			if (s_last) begin
				wr_act <= {wr_act[BUF_NUM-2:0], wr_act[BUF_NUM-1]};
				lines_left <= lines_left - reso_t'(1);
				last_line <= (lines_left == reso_t'(2));
			end
			// Open the input once the next target is free
			if (!o_s_tready && |(wr_act & ~lb.buf_valid))
				o_s_tready <= 1'b1;
			else if (s_last)
				o_s_tready <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (s_next) begin
			o_wr_addr <= col;
			o_wr_data <= i_s_tdata;
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			lb.buf_valid <= '0;
			lb.buf_last_line <= '0;
		end else begin
			for (int i = 0; i < BUF_NUM; i++) begin
				if (s_last && wr_act[i]) begin
					lb.buf_valid[i] <= 1'b1;
					lb.buf_last_line[i] <= last_line;
				end else if (lb.buf_release && !lb.first_line
						&& lb.rd_sel_prev == buf_sel_t'(i)) begin
					lb.buf_valid[i] <= 1'b0;
				end
			end
		end
	end

	// No pixel lands in a buffer still holding an unread line
	assert property (@(posedge clk) disable iff (int_reset)
		s_next |-> (wr_act & lb.buf_valid) == '0);

endmodule

// ==== rtl/line_buffer.sv ====
module line_buffer import yscale_pkg::*; (
	input  logic   clk,
	input  logic   i_wr_en,
	input  reso_t  i_wr_addr,
	input  pixel_t i_wr_data,
	input  logic   i_rd_en,
	input  reso_t  i_rd_addr,
	output pixel_t o_rd_data
);

	pixel_t mem [2**RESO_WIDTH];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Read data holds while i_rd_en is low
	always_ff @(posedge clk) begin
		if (i_rd_en)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

// ==== rtl/blend_if.sv ====
interface blend_if import yscale_pkg::*; ();

	logic   valid;
	logic   ready;
	pixel_t pix_prev;
	pixel_t pix_cur;
	// Weight of the current line is implied
	ratio_t weight_prev;
	logic   last;

	modport src (
		output valid, pix_prev, pix_cur, weight_prev, last,
		input  ready
	);
	modport dst (
		input  valid, pix_prev, pix_cur, weight_prev, last,
		output ready
	);

endinterface

// ==== rtl/line_buf_if.sv ====
interface line_buf_if import yscale_pkg::*; ();

	logic [BUF_NUM-1:0] buf_valid;
	logic [BUF_NUM-1:0] buf_last_line;
	logic               buf_release;
	buf_sel_t           rd_sel;
	buf_sel_t           rd_sel_prev;
	logic               first_line;

	modport writer (
		output buf_valid, buf_last_line,
		input  buf_release, rd_sel_prev, first_line
	);
	modport ctrl (
		input  buf_valid, buf_last_line,
		output buf_release, rd_sel, rd_sel_prev, first_line
	);
	modport reader (input rd_sel, rd_sel_prev);

endinterface

// ==== rtl/yscale_pkg.sv ====
package yscale_pkg;

	// Pixel and raster sizes
	localparam int PIXEL_WIDTH = 8;
	localparam int RESO_WIDTH = 10;

	// Line buffer rotation
	localparam int BUF_IDX_WIDTH = 2;
	localparam int BUF_NUM = 2 ** BUF_IDX_WIDTH;

	// Blend weight in quarters, 0 to SPLIT_NUM inclusive
	localparam int SPLIT_NUM = 4;
	localparam int RATIO_WIDTH = 3;

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [RESO_WIDTH-1:0] reso_t;
	typedef logic [RATIO_WIDTH-1:0] ratio_t;
	typedef logic [BUF_IDX_WIDTH-1:0] buf_sel_t;

	// Line positions scaled by both heights
	typedef logic [2*RESO_WIDTH-1:0] phase_t;

endpackage
